// File: chess_pkg.sv
/* Chess board encoding for the material evaluator
   A square code is a black flag above a 3-bit piece kind */
`default_nettype none

package chess_pkg;

   localparam int SQUARE_COUNT = 64;                       // Squares per board
   localparam int PIECE_WIDTH = 4;                         // Bits per square code
   localparam int KIND_WIDTH = PIECE_WIDTH - 1;            // Kind field under the colour flag
   localparam int BOARD_WIDTH = SQUARE_COUNT * PIECE_WIDTH; // 256-bit board word
   localparam int SQUARE_INDEX_WIDTH = $clog2(SQUARE_COUNT); // 6-bit square number

   // Piece kinds, colour stripped
   localparam logic [KIND_WIDTH-1:0] KIND_EMPTY = 3'd0;
   localparam logic [KIND_WIDTH-1:0] KIND_PAWN = 3'd1;
   localparam logic [KIND_WIDTH-1:0] KIND_KNIGHT = 3'd2;    // First kind that adds to phase
   localparam logic [KIND_WIDTH-1:0] KIND_BISHOP = 3'd3;
   localparam logic [KIND_WIDTH-1:0] KIND_ROOK = 3'd4;
   localparam logic [KIND_WIDTH-1:0] KIND_QUEEN = 3'd5;
   localparam logic [KIND_WIDTH-1:0] KIND_KING = 3'd6;      // Last kind that adds to phase
   // Kind 7 is unused and scores nothing

   // Decoded view of one square
   typedef struct packed
   {
      logic black;                                         // Set for black pieces
      logic [KIND_WIDTH-1:0] kind;                         // Piece kind
   } square_fields_t;

   // Same 4 bits seen raw or split into colour and kind
   typedef union packed
   {
      logic [PIECE_WIDTH-1:0] raw;                         // Whole code, empty test
      square_fields_t fields;                              // Value lookup and sign
   } square_code_u;

endpackage

`default_nettype wire

// File: eval_pkg.sv
/* Evaluation constants: tapered piece values, phase range and blend scaling
   Phase blend multiplies by a rounded-down reciprocal in place of a divide */
`default_nettype none

package eval_pkg;

   localparam int EVAL_WIDTH_DEFAULT = 16;                 // Signed score width

   // Middle-game values by kind: empty, P, N, B, R, Q, K, unused
   localparam int MG_VALUE [0:7] = '{0, 82, 337, 365, 477, 1025, 0, 0};

   // End-game values, same order
   localparam int EG_VALUE [0:7] = '{0, 94, 281, 297, 512, 936, 0, 0};

   localparam int PHASE_WIDTH = 7;                         // Holds a count up to 64
   localparam logic [PHASE_WIDTH-1:0] PHASE_MAX = 7'd62;   // Full middle-game phase

   localparam int SCALE_SHIFT = 20;                        // Fixed-point divide by 2^20
   localparam int SCALE_RECIP = (1 << SCALE_SHIFT) / int'(PHASE_MAX); // 16912

   localparam int BLEND_STAGES = 6;                        // Blend pipeline depth

   // Edge to eval_valid: capture, scan start, 64 squares, totals, blend
   localparam int EVAL_LATENCY = 71;

endpackage

`default_nettype wire

// File: material_if.sv
/* Scan totals passed from the material scanner to the taper blend */
`timescale 1ns/10ps
`default_nettype none

interface material_if
  #(
    parameter int EVAL_WIDTH = eval_pkg::EVAL_WIDTH_DEFAULT
    );

   logic signed [EVAL_WIDTH-1:0] mg_total;                 // Signed middle-game sum
   logic signed [EVAL_WIDTH-1:0] eg_total;                 // Signed end-game sum
   logic [eval_pkg::PHASE_WIDTH-1:0] phase_count;          // Non-pawn piece count
   logic totals_valid;                                     // One-cycle pulse, no handshake

   modport source
     (
      output mg_total,
      output eg_total,
      output phase_count,
      output totals_valid
      );

   modport sink
     (
      input mg_total,
      input eg_total,
      input phase_count,
      input totals_valid
      );

endinterface

`default_nettype wire

// File: eval_fsm.sv
/* Evaluation control FSM: board edge detect, scan launch,
   blend drain count and result hold until cleared */
`timescale 1ns/10ps
`default_nettype none

module eval_fsm
  (
   input logic clk,
   input logic reset,
   input logic board_valid,
   input logic clear_eval,
   input logic scan_done,
   output logic capture,
   output logic scan_start,
   output logic eval_valid
   );

   typedef enum logic [2:0]
   {
      ST_IDLE,                                             // Board register tracks board_in
      ST_WAIT_STATE,                                       // Board settled, launch scan
      ST_SCAN,                                             // Timer walking the squares
      ST_WAIT_LATENCY,                                     // Blend pipeline draining
      ST_WAIT_CLEAR                                        // Result held
   } state_t;

   localparam int DRAIN_WIDTH = $clog2(eval_pkg::BLEND_STAGES);

   state_t state;
   logic board_valid_r;                                    // Previous board_valid
   logic board_edge;
   logic [DRAIN_WIDTH-1:0] drain_count;                    // Cycles since scan_done

   assign board_edge = board_valid && !board_valid_r;      // Rising edge only
   assign capture = (state == ST_IDLE);
   assign scan_start = (state == ST_WAIT_STATE);           // Single cycle by construction
   assign eval_valid = (state == ST_WAIT_CLEAR);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= ST_IDLE;
         board_valid_r <= 1'b0;
         drain_count <= '0;
      end
      else
      begin
         board_valid_r <= board_valid;
         case (state)
            ST_IDLE:
               if (board_edge)
                  state <= ST_WAIT_STATE;                  // Board captured on this edge
            ST_WAIT_STATE:
               state <= ST_SCAN;
            ST_SCAN:
            begin
               drain_count <= '0;
               if (scan_done)
                  state <= ST_WAIT_LATENCY;
            end
            ST_WAIT_LATENCY:
            begin
               drain_count <= drain_count + 1'b1;
               if (drain_count == DRAIN_WIDTH'(eval_pkg::BLEND_STAGES - 1))
                  state <= ST_WAIT_CLEAR;                  // eval register now loaded
            end
            ST_WAIT_CLEAR:
               if (clear_eval)
                  state <= ST_IDLE;
            default:
               state <= ST_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: square_timer.sv
/* Scan timer: steps through the 64 squares and flags the last one */
`timescale 1ns/10ps
`default_nettype none

module square_timer
  (
   input logic clk,
   input logic reset,
   input logic scan_start,
   output logic [chess_pkg::SQUARE_INDEX_WIDTH-1:0] square,
   output logic scan_active,
   output logic scan_done
   );

   localparam logic [chess_pkg::SQUARE_INDEX_WIDTH-1:0] LAST_SQUARE =
      chess_pkg::SQUARE_INDEX_WIDTH'(chess_pkg::SQUARE_COUNT - 1);

   assign scan_done = scan_active && (square == LAST_SQUARE); // Pulses with square 63

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         square <= '0;
         scan_active <= 1'b0;
      end
      else if (scan_start)
      begin
         square <= '0;                                     // Restart from square 0
         scan_active <= 1'b1;
      end
      else if (scan_active)
      begin
         square <= square + 1'b1;                          // Wraps to 0 after the last square
         if (scan_done)
            scan_active <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: material_scanner.sv
/* Material scanner: holds the board and accumulates signed piece values
   and the non-pawn phase count one square per clock */
`timescale 1ns/10ps
`default_nettype none

module material_scanner
  #(
    parameter int EVAL_WIDTH = eval_pkg::EVAL_WIDTH_DEFAULT
    )
   (
    input logic clk,
    input logic reset,
    input logic capture,
    input logic [chess_pkg::BOARD_WIDTH-1:0] board_in,
    input logic [chess_pkg::SQUARE_INDEX_WIDTH-1:0] square,
    input logic scan_active,
    input logic scan_done,
    material_if.source totals
    );

   logic [chess_pkg::BOARD_WIDTH-1:0] board;               // Captured board
   chess_pkg::square_code_u code;                          // Current square
   logic occupied;
   logic counts_phase;                                     // Knight through king
   logic signed [EVAL_WIDTH-1:0] mg_step;
   logic signed [EVAL_WIDTH-1:0] eg_step;

   always_ff @(posedge clk)
      if (capture)
         board <= board_in;                                // Follows input while idle

   assign code = board[square * chess_pkg::PIECE_WIDTH +: chess_pkg::PIECE_WIDTH];
   assign occupied = (code.raw != {1'b0, chess_pkg::KIND_EMPTY});
   assign counts_phase = occupied &&
                         (code.fields.kind >= chess_pkg::KIND_KNIGHT) &&
                         (code.fields.kind <= chess_pkg::KIND_KING);

   // Table value, negated for black
   always_comb
   begin
      mg_step = '0;
      eg_step = '0;
      if (occupied)
      begin
         mg_step = EVAL_WIDTH'(eval_pkg::MG_VALUE[code.fields.kind]);
         eg_step = EVAL_WIDTH'(eval_pkg::EG_VALUE[code.fields.kind]);
         if (code.fields.black)
         begin
            mg_step = -mg_step;
            eg_step = -eg_step;
         end
      end
   end

   // Sums clear between scans, hold the final values for one cycle after
   always_ff @(posedge clk)
   begin
      if (!scan_active)
      begin
         totals.mg_total <= '0;
         totals.eg_total <= '0;
         totals.phase_count <= '0;
      end
      else
      begin
         totals.mg_total <= totals.mg_total + mg_step;
         totals.eg_total <= totals.eg_total + eg_step;
         totals.phase_count <= totals.phase_count +
                               {{(eval_pkg::PHASE_WIDTH - 1){1'b0}}, counts_phase};
      end
   end

   always_ff @(posedge clk)
      if (reset)
         totals.totals_valid <= 1'b0;
      else
         totals.totals_valid <= scan_done;                 // Last square now summed

endmodule

`default_nettype wire

// File: taper_blend.sv
/* Taper blend pipeline: clamps the phase and mixes middle-game and
   end-game totals, scaled by a reciprocal multiply and shift */
`timescale 1ns/10ps
`default_nettype none

module taper_blend
  #(
    parameter int EVAL_WIDTH = eval_pkg::EVAL_WIDTH_DEFAULT
    )
   (
    input logic clk,
    input logic reset,
    material_if.sink totals,
    output logic signed [EVAL_WIDTH-1:0] eval
    );

   localparam int PROD_WIDTH = EVAL_WIDTH + eval_pkg::PHASE_WIDTH + 1;
   localparam int SUM_WIDTH = PROD_WIDTH + 1;
   localparam int SCALED_WIDTH = SUM_WIDTH + $clog2(eval_pkg::SCALE_RECIP) + 1;

   logic [eval_pkg::PHASE_WIDTH-1:0] phase_clamped;
   logic [eval_pkg::PHASE_WIDTH-1:0] phase_s1;             // Stage 1, phase and totals
   logic signed [EVAL_WIDTH-1:0] mg_s1;
   logic signed [EVAL_WIDTH-1:0] eg_s1;
   logic [eval_pkg::PHASE_WIDTH-1:0] phase_rest;           // End-game weight
   logic signed [PROD_WIDTH-1:0] mg_prod_s2;               // Stage 2, weighted totals
   logic signed [PROD_WIDTH-1:0] eg_prod_s2;
   logic signed [SUM_WIDTH-1:0] sum_s3;                    // Stage 3
   logic signed [SCALED_WIDTH-1:0] scaled_s4;              // Stage 4, times reciprocal
   logic signed [SCALED_WIDTH-1:0] round_bias;
   logic signed [SCALED_WIDTH-1:0] shifted_s5;             // Stage 5, divided by 2^20

   assign phase_clamped = (totals.phase_count > eval_pkg::PHASE_MAX) ?
                          eval_pkg::PHASE_MAX : totals.phase_count;
   assign phase_rest = eval_pkg::PHASE_MAX - phase_s1;

   // Negative values need a bias so the shift truncates toward zero
   assign round_bias = scaled_s4[SCALED_WIDTH-1] ?
                       SCALED_WIDTH'((1 << eval_pkg::SCALE_SHIFT) - 1) : '0;

   always_ff @(posedge clk)
      if (totals.totals_valid)
      begin
         phase_s1 <= phase_clamped;
         mg_s1 <= totals.mg_total;
         eg_s1 <= totals.eg_total;
      end

   always_ff @(posedge clk)
   begin
      mg_prod_s2 <= mg_s1 * $signed({1'b0, phase_s1});
      eg_prod_s2 <= eg_s1 * $signed({1'b0, phase_rest});
      sum_s3 <= mg_prod_s2 + eg_prod_s2;
      scaled_s4 <= sum_s3 * eval_pkg::SCALE_RECIP;
      shifted_s5 <= (scaled_s4 + round_bias) >>> eval_pkg::SCALE_SHIFT;
   end

   always_ff @(posedge clk)
      if (reset)
         eval <= '0;
      else
         eval <= shifted_s5[EVAL_WIDTH-1:0];               // Wraps to score width

endmodule

`default_nettype wire

// File: eval_top.sv
/* Tapered material evaluator top level: FSM, square timer,
   material scanner and blend pipeline */
`timescale 1ns/10ps
`default_nettype none

module eval_top
  #(
    parameter int EVAL_WIDTH = eval_pkg::EVAL_WIDTH_DEFAULT
    )
   (
    input logic clk,
    input logic reset,
    input logic board_valid,
    input logic [chess_pkg::BOARD_WIDTH-1:0] board_in,
    input logic clear_eval,
    output logic signed [EVAL_WIDTH-1:0] eval,
    output logic eval_valid
    );

   logic capture;
   logic scan_start;
   logic [chess_pkg::SQUARE_INDEX_WIDTH-1:0] square;
   logic scan_active;
   logic scan_done;

   material_if #(.EVAL_WIDTH(EVAL_WIDTH)) totals_bus ();   // Scanner to blend

   eval_fsm i_eval_fsm
     (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .scan_done   (scan_done),
      .capture     (capture),
      .scan_start  (scan_start),
      .eval_valid  (eval_valid)
      );

   square_timer i_square_timer
     (
      .clk         (clk),
      .reset       (reset),
      .scan_start  (scan_start),
      .square      (square),
      .scan_active (scan_active),
      .scan_done   (scan_done)
      );

   material_scanner #(.EVAL_WIDTH(EVAL_WIDTH)) i_material_scanner
     (
      .clk         (clk),
      .reset       (reset),
      .capture     (capture),
      .board_in    (board_in),
      .square      (square),
      .scan_active (scan_active),
      .scan_done   (scan_done),
      .totals      (totals_bus.source)
      );

   taper_blend #(.EVAL_WIDTH(EVAL_WIDTH)) i_taper_blend
     (
      .clk         (clk),
      .reset       (reset),
      .totals      (totals_bus.sink),
      .eval        (eval)
      );

endmodule

`default_nettype wire

// File: tb_clock.sv
/* Testbench clock and reset: 10 ns clock, reset held for 10 cycles */
`timescale 1ns/10ps
`default_nettype none

module tb_clock
  (
   output logic clk,
   output logic reset
   );

   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;                                    // 10 ns period
   end

   initial
   begin
      reset = 1'b1;
      repeat (10)
         @(posedge clk);
      #1 reset = 1'b0;                                     // Released 1 ns after the edge
   end

endmodule

`default_nettype wire

// File: eval_asserts.sv
/* Protocol and latency assertions for the material evaluator,
   bound to the top level */
`timescale 1ns/10ps
`default_nettype none

module eval_asserts
  #(
    parameter int EVAL_WIDTH = eval_pkg::EVAL_WIDTH_DEFAULT
    )
   (
    input logic clk,
    input logic reset,
    input logic board_valid,
    input logic capture,
    input logic clear_eval,
    input logic signed [EVAL_WIDTH-1:0] eval,
    input logic eval_valid
    );

   int fail_count = 0;                                     // Failed assertion count
   logic board_valid_q;                                    // Previous board_valid
   logic start;                                            // Board edge taken while idle

   always_ff @(posedge clk)
      if (reset)
         board_valid_q <= 1'b0;
      else
         board_valid_q <= board_valid;

   assign start = capture && board_valid && !board_valid_q;

   // eval_valid is set by edge E71, first sampled high one tick later
   latency_check: assert property (@(posedge clk) disable iff (reset)
      start |=> !eval_valid [*eval_pkg::EVAL_LATENCY] ##1 eval_valid)
   else
   begin
      fail_count++;
      $error("eval_valid did not rise EVAL_LATENCY cycles after the board edge");
   end

   // Every result belongs to an accepted board edge
   origin_check: assert property (@(posedge clk) disable iff (reset)
      $rose(eval_valid) |-> $past(start, eval_pkg::EVAL_LATENCY + 1))
   else
   begin
      fail_count++;
      $error("eval_valid rose without an accepted board edge");
   end

   hold_check: assert property (@(posedge clk) disable iff (reset)
      eval_valid && !clear_eval |=> eval_valid && $stable(eval))
   else
   begin
      fail_count++;
      $error("Result was not held while clear_eval was low");
   end

   clear_check: assert property (@(posedge clk) disable iff (reset)
      eval_valid && clear_eval |=> !eval_valid)
   else
   begin
      fail_count++;
      $error("eval_valid stayed high after clear_eval");
   end

endmodule

`default_nettype wire

// File: tb_eval.sv
/* Material evaluator testbench with fixed and random boards checked
   against a table model of the tapered blend */
`timescale 1ns/10ps
`default_nettype none

module tb_eval;

   localparam int EVAL_WIDTH = 24;                         // Headroom for full-board totals
   localparam int WAIT_LIMIT = 4 * eval_pkg::EVAL_LATENCY; // Cycles before a wait gives up
   localparam int RANDOM_BOARDS = 40;
   localparam logic [2:0] BACK_RANK [0:7] = '{chess_pkg::KIND_ROOK, chess_pkg::KIND_KNIGHT,
      chess_pkg::KIND_BISHOP, chess_pkg::KIND_QUEEN, chess_pkg::KIND_KING,
      chess_pkg::KIND_BISHOP, chess_pkg::KIND_KNIGHT, chess_pkg::KIND_ROOK};

   typedef logic [chess_pkg::BOARD_WIDTH-1:0] board_t;
   typedef logic signed [EVAL_WIDTH-1:0] score_t;

   logic clk;
   logic reset;
   logic board_valid;
   board_t board_in;
   logic clear_eval;
   score_t eval;
   logic eval_valid;
   int value_errors;
   int timeout_errors;
   int cycles;
   board_t board_a;
   board_t board_b;
   score_t expected;

   tb_clock i_tb_clock (.clk(clk), .reset(reset));

   eval_top #(.EVAL_WIDTH(EVAL_WIDTH)) i_eval_top
     (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .board_in    (board_in),
      .clear_eval  (clear_eval),
      .eval        (eval),
      .eval_valid  (eval_valid)
      );

   bind eval_top eval_asserts #(.EVAL_WIDTH(EVAL_WIDTH)) i_eval_asserts
     (.clk(clk), .reset(reset), .board_valid(board_valid), .capture(capture),
      .clear_eval(clear_eval), .eval(eval), .eval_valid(eval_valid));

   function automatic logic [3:0] piece(logic black, logic [2:0] kind);
      chess_pkg::square_code_u code;
      code.fields.black = black;
      code.fields.kind = kind;
      return code.raw;
   endfunction

   function automatic board_t place(board_t board, int square, logic [3:0] code);
      board[square * chess_pkg::PIECE_WIDTH +: chess_pkg::PIECE_WIDTH] = code;
      return board;
   endfunction

   // Back rank and pawn row of one side
   function automatic board_t army(logic black, int back_row, int pawn_row, board_t board);
      for (int file = 0; file < 8; file++)
      begin
         board = place(board, back_row * 8 + file, piece(black, BACK_RANK[file]));
         board = place(board, pawn_row * 8 + file, piece(black, chess_pkg::KIND_PAWN));
      end
      return board;
   endfunction

   // Table sums, phase clamp, blend, divide truncating toward zero
   function automatic score_t model_eval(board_t board);
      chess_pkg::square_code_u code;
      longint mg;
      longint eg;
      longint phase;
      longint phase_max;
      longint blended;
      mg = 0;
      eg = 0;
      phase = 0;
      phase_max = longint'(eval_pkg::PHASE_MAX);
      for (int sq = 0; sq < chess_pkg::SQUARE_COUNT; sq++)
      begin
         code.raw = board[sq * chess_pkg::PIECE_WIDTH +: chess_pkg::PIECE_WIDTH];
         if (code.fields.black)
         begin
            mg -= eval_pkg::MG_VALUE[code.fields.kind];
            eg -= eval_pkg::EG_VALUE[code.fields.kind];
         end
         else
         begin
            mg += eval_pkg::MG_VALUE[code.fields.kind];
            eg += eval_pkg::EG_VALUE[code.fields.kind];
         end
         if (code.fields.kind >= chess_pkg::KIND_KNIGHT &&
             code.fields.kind <= chess_pkg::KIND_KING)
            phase++;                                       // Kings count too
      end
      if (phase > phase_max)
         phase = phase_max;
      blended = (mg * phase + eg * (phase_max - phase)) * eval_pkg::SCALE_RECIP;
      return score_t'(blended / (longint'(1) << eval_pkg::SCALE_SHIFT));
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;                                                  // Drive and sample after the edge
   endtask

   task automatic launch(board_t board);
      board_in = board;
      board_valid = 1'b1;                                  // Low on the previous edge
      next_cycle();
      board_valid = 1'b0;
   endtask

   task automatic wait_for_valid();
      int waited;
      waited = 0;
      while (!eval_valid && waited < WAIT_LIMIT)
      begin
         next_cycle();
         waited++;
      end
      if (!eval_valid)
      begin
         $display("Timeout: eval_valid did not rise within %0d cycles", WAIT_LIMIT);
         timeout_errors++;
      end
   endtask

   task automatic check_eval(score_t want);
      assert (eval === want)
      else
      begin
         $display("Mismatch eval: got %h expected %h", eval, want);
         value_errors++;
      end
   endtask

   task automatic check_idle();
      assert (eval_valid === 1'b0)
      else
      begin
         $display("Mismatch eval_valid: got %h expected 0", eval_valid);
         value_errors++;
      end
   endtask

   // Hold the result, then clear it for one cycle
   task automatic release_eval(int hold_cycles);
      repeat (hold_cycles)
         next_cycle();
      clear_eval = 1'b1;
      next_cycle();
      clear_eval = 1'b0;
      check_idle();                                        // Low one cycle after clear
   endtask

   task automatic evaluate(board_t board, score_t want, int hold_cycles);
      launch(board);
      wait_for_valid();
      check_eval(want);
      release_eval(hold_cycles);
   endtask

   initial
   begin
      board_valid = 1'b0;
      board_in = '0;
      clear_eval = 1'b0;
      value_errors = 0;
      timeout_errors = 0;
      void'($urandom(32'he753_96f8));                      // One seed for the whole run
      cycles = 0;
      while (reset !== 1'b0 && cycles < WAIT_LIMIT)
      begin
         next_cycle();
         cycles++;
      end
      if (reset !== 1'b0)
      begin
         $display("Timeout: reset was never released");
         timeout_errors++;
      end
      repeat (100)
      begin
         next_cycle();
         check_idle();                                     // No result without a board
      end

      board_a = army(1'b1, 7, 6, army(1'b0, 0, 1, '0));    // Start position
      evaluate(board_a, '0, 2);
      board_a = army(1'b0, 0, 1, '0);                      // White only
      expected = model_eval(board_a);
      assert (expected > 0)
      else
      begin
         $display("White-only board did not give a positive expected value");
         value_errors++;
      end
      evaluate(board_a, expected, 3);
      board_b = army(1'b1, 0, 1, '0);                      // Same squares, black
      evaluate(board_b, -expected, 1);

      for (int n = 0; n < RANDOM_BOARDS; n++)
      begin
         for (int sq = 0; sq < chess_pkg::SQUARE_COUNT; sq++)
            board_a = place(board_a, sq, 4'($urandom_range(0, 15)));
         evaluate(board_a, model_eval(board_a), $urandom_range(0, 20));
      end

      // Phase counts of 64 clamped to 62
      for (int sq = 0; sq < chess_pkg::SQUARE_COUNT; sq++)
      begin
         board_a = place(board_a, sq, piece(1'b0, chess_pkg::KIND_QUEEN));
         board_b = place(board_b, sq, (sq < 40) ? piece(1'b0, chess_pkg::KIND_KNIGHT) :
                                                  piece(1'b1, chess_pkg::KIND_ROOK));
      end
      evaluate(board_a, model_eval(board_a), 0);
      evaluate(board_b, model_eval(board_b), 0);

      // Busy pulse and new board are ignored
      board_a = army(1'b0, 0, 1, '0);
      board_b = army(1'b1, 7, 6, '0);
      launch(board_a);
      repeat (10)
         next_cycle();
      board_in = board_b;
      board_valid = 1'b1;
      next_cycle();
      board_valid = 1'b0;
      repeat (10)
         next_cycle();
      board_valid = 1'b1;                                  // Held high across the clear
      wait_for_valid();
      check_eval(model_eval(board_a));
      release_eval(0);
      repeat (50)
      begin
         next_cycle();
         check_idle();                                     // No edge, no second run
      end
      board_valid = 1'b0;
      next_cycle();
      evaluate(board_b, model_eval(board_b), 0);
      next_cycle();
      next_cycle();

      $display("Errors: %0d value, %0d timeout, %0d assertion", value_errors,
               timeout_errors, i_eval_top.i_eval_asserts.fail_count);
      if (value_errors + timeout_errors + i_eval_top.i_eval_asserts.fail_count == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
chess_pkg.sv
eval_pkg.sv
material_if.sv
eval_fsm.sv
square_timer.sv
material_scanner.sv
taper_blend.sv
eval_top.sv
tb_clock.sv
eval_asserts.sv
tb_eval.sv
